/* Bender.yml */
package:
  name: lcd_shield_ctrl

sources:
  # packages first, then the blocks, then the top level
  - files:
      - verilog/lcd_cmd_pkg.sv
      - verilog/spi_link_pkg.sv
      - verilog/lcd_spi_serializer.sv
      - verilog/lcd_cmd_sequencer.sv
      - verilog/lcd_shield_top.sv

  # simulation only
  - target: test
    files:
      - tests/spi_frame_monitor.sv
      - tests/tb_lcd_shield.sv

/* tests/spi_frame_monitor.sv */
`timescale 1ns/1ps
`default_nettype none

// rebuilds each spi frame from the display pins
module spi_frame_monitor
(
  input  wire        clk,
  input  wire        rst,
  input  wire        sck,
  input  wire        data,
  input  wire        cs,
  input  wire        rs_dc,
  output logic       frame_done,
  output logic [7:0] frame_byte,
  output logic       frame_rs_dc,
  output int         frame_edges,
  output int         frame_low,
  output int         frame_gap
);

  logic       sck_q;
  logic       cs_q;
  logic       dc_q;
  logic [7:0] shift_q;
  int         edge_cnt;
  int         low_cnt;
  int         high_cnt;
  int         gap_q;

  // pins sampled mid-cycle, well away from the clk edge
  always @(negedge clk)
  begin
    frame_done <= 1'b0;
    if (rst)
    begin
      sck_q    <= 1'b0;
      cs_q     <= 1'b1;
      dc_q     <= 1'b0;
      shift_q  <= '0;
      edge_cnt <= 0;
      low_cnt  <= 0;
      high_cnt <= 0;
      gap_q    <= 0;
    end
    else
    begin
      sck_q <= sck;
      cs_q  <= cs;
      if (!cs)
      begin
        low_cnt <= low_cnt + 1;
        // mode 0, display takes the bit on rising sck
        if (sck && !sck_q)
        begin
          shift_q  <= {shift_q[6:0], data};
          edge_cnt <= edge_cnt + 1;
          dc_q     <= rs_dc;
        end
      end
      else
      begin
        high_cnt <= high_cnt + 1;
      end
      // cs fall opens a new frame
      if (!cs && cs_q)
      begin
        gap_q    <= high_cnt;
        low_cnt  <= 1;
        edge_cnt <= (sck && !sck_q) ? 1 : 0;
      end
      // cs rise closes it, one strobe per byte
      if (cs && !cs_q)
      begin
        frame_done  <= 1'b1;
        frame_byte  <= shift_q;
        frame_rs_dc <= dc_q;
        frame_edges <= edge_cnt;
        frame_low   <= low_cnt;
        frame_gap   <= gap_q;
        high_cnt    <= 1;
      end
    end
  end

endmodule : spi_frame_monitor

`default_nettype wire

/* tests/tb_lcd_shield.sv */
`timescale 1ns/1ps
`default_nettype none

// testbench for the tft shield command controller
module tb_lcd_shield
  import lcd_cmd_pkg::*, spi_link_pkg::*;
;

  // delay shorter than a frame so the sequencer waits on the serializer
  localparam delay_t TB_DELAY = 21'd60;
  localparam int NUM_FRAMES = 6;
  localparam int FRAME_CYCLES = 8 * SPI_CLK_DIV;
  localparam int WAIT_LIMIT = 2000;

  logic clk;
  logic rst;
  wire  inv;
  wire  sck;
  wire  rs_dc;
  wire  data;
  wire  cs;

  logic       frame_done;
  logic [7:0] frame_byte;
  logic       frame_rs_dc;
  int         frame_edges;
  int         frame_low;
  int         frame_gap;

  int errors = 0;
  int tests_run = 0;
  int tests_failed = 0;
  int test_start_errors = 0;
  int sck_idle_errors = 0;
  int mode0_errors = 0;
  int sck_high_seen = 0;
  logic prev_data = 1'b0;

  cmd_byte_t expected_q[$];
  cmd_byte_t got_byte[NUM_FRAMES];
  logic      got_dc[NUM_FRAMES];
  logic      got_inv[NUM_FRAMES];
  int        got_edges[NUM_FRAMES];
  int        got_low[NUM_FRAMES];
  int        got_gap[NUM_FRAMES];

  lcd_shield_top #(
    .DELAY_CYCLES (TB_DELAY)
  ) dut_i (
    .clk   (clk),
    .rst   (rst),
    .inv   (inv),
    .sck   (sck),
    .rs_dc (rs_dc),
    .data  (data),
    .cs    (cs)
  );

  spi_frame_monitor mon_i (
    .clk         (clk),
    .rst         (rst),
    .sck         (sck),
    .data        (data),
    .cs          (cs),
    .rs_dc       (rs_dc),
    .frame_done  (frame_done),
    .frame_byte  (frame_byte),
    .frame_rs_dc (frame_rs_dc),
    .frame_edges (frame_edges),
    .frame_low   (frame_low),
    .frame_gap   (frame_gap)
  );

  // 10 ns clock
  always #5 clk = ~clk;

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] expected);
    assert (got === expected)
    else
    begin
      $display("Fail %s: got 0x%0h, expected 0x%0h", name, got, expected);
      errors++;
    end
  endtask

  // idle pin levels while and just after reset
  task automatic check_idle_pins();
    check_value("cs", cs, 1);
    check_value("sck", sck, 0);
    check_value("data", data, 0);
    check_value("inv", inv, 0);
  endtask

  task automatic report_test(input string name);
    tests_run++;
    if (errors > test_start_errors)
    begin
      tests_failed++;
      $display("test %s: failed", name);
    end
    else
    begin
      $display("test %s: passed", name);
    end
    test_start_errors = errors;
  endtask

  // next monitor strobe, then inv once the cycle has settled
  task automatic wait_frame(input int idx);
    int  n;
    bit  ok;
    n = 0;
    ok = 1'b0;
    while (!ok && n < WAIT_LIMIT)
    begin
      @(posedge clk);
      n++;
      if (frame_done)
      begin
        ok = 1'b1;
      end
    end
    if (ok)
    begin
      got_byte[idx] = frame_byte;
      got_dc[idx] = frame_rs_dc;
      got_edges[idx] = frame_edges;
      got_low[idx] = frame_low;
      got_gap[idx] = frame_gap;
      // next cs fall is at least one edge away
      @(negedge clk);
      got_inv[idx] = inv;
    end
    else
    begin
      $display("timeout while waiting for frame %0d to finish", idx);
      errors++;
    end
  endtask

  // per-cycle pin rules
  always @(negedge clk)
  begin
    if (!rst)
    begin
      if (cs)
      begin
        assert (sck === 1'b0)
        else
        begin
          $display("Fail sck: got 0x%0h while cs high, expected 0x0", sck);
          sck_idle_errors++;
        end
      end
      else if (sck)
      begin
        sck_high_seen++;
        // in mode 0 data only moves while sck is low
        assert (data === prev_data)
        else
        begin
          $display("data changed while sck was high at %0t", $time);
          mode0_errors++;
        end
      end
    end
    prev_data = data;
  end

  initial
  begin
    int n;
    bit ok;
    int spacing;
    int exp_spacing;
    logic exp_inv;
    clk = 1'b0;
    rst = 1'b1;

    // startup list, then inversion on and off in turn
    expected_q.push_back(CMD_SLPOUT);
    expected_q.push_back(CMD_DISPON);
    while (expected_q.size() < NUM_FRAMES)
    begin
      expected_q.push_back(CMD_INVON);
      expected_q.push_back(CMD_INVOFF);
    end

    // reset held for 4 edges with pins checked during and after
    repeat (3) @(posedge clk);
    @(negedge clk);
    check_idle_pins();
    @(posedge clk);
    #1 rst = 1'b0;
    @(negedge clk);
    check_idle_pins();

    // first cs fall counted in edges after reset release
    n = 0;
    ok = 1'b0;
    while (!ok && n < WAIT_LIMIT)
    begin
      @(posedge clk);
      n++;
      @(negedge clk);
      if (!cs)
      begin
        ok = 1'b1;
      end
    end
    if (ok)
    begin
      check_value("first cs fall cycle", n, TB_DELAY + 2);
    end
    else
    begin
      $display("timeout while waiting for the first cs fall");
      errors++;
    end
    report_test("reset_state");

    for (int i = 0; i < NUM_FRAMES; i++)
    begin
      wait_frame(i);
    end

    for (int i = 0; i < NUM_FRAMES; i++)
    begin
      check_value("cmd byte", got_byte[i], expected_q[i]);
      check_value("rs_dc", got_dc[i], 0);
    end
    report_test("command_order");

    for (int i = 0; i < NUM_FRAMES; i++)
    begin
      check_value("sck rising edges", got_edges[i], 8);
      check_value("cs low cycles", got_low[i], FRAME_CYCLES);
    end
    assert (sck_idle_errors == 0)
    else
    begin
      $display("sck was high while cs was high in %0d cycles", sck_idle_errors);
      errors++;
    end
    report_test("frame_shape");

    assert (sck_high_seen > 0 && mode0_errors == 0)
    else
    begin
      $display("mode 0 timing broken or sck never seen high");
      errors++;
    end
    report_test("mode0_timing");

    // inv follows the last accepted inversion command
    exp_inv = 1'b0;
    for (int i = 0; i < NUM_FRAMES; i++)
    begin
      if (expected_q[i] == CMD_INVON)
      begin
        exp_inv = 1'b1;
      end
      else if (expected_q[i] == CMD_INVOFF)
      begin
        exp_inv = 1'b0;
      end
      check_value("inv", got_inv[i], exp_inv);
    end
    report_test("inversion_flag");

    // fall to fall is the longer of delay and frame
    if (TB_DELAY + 2 > FRAME_CYCLES + 2)
    begin
      exp_spacing = TB_DELAY + 2;
    end
    else
    begin
      exp_spacing = FRAME_CYCLES + 2;
    end
    for (int i = 1; i < NUM_FRAMES; i++)
    begin
      spacing = got_low[i-1] + got_gap[i];
      check_value("cs fall spacing", spacing, exp_spacing);
      // cs high for whatever the spacing leaves after a full frame
      check_value("cs high cycles", got_gap[i], exp_spacing - FRAME_CYCLES);
      assert (got_byte[i] !== got_byte[i-1])
      else
      begin
        $display("frame %0d repeats the byte of the frame before it", i);
        errors++;
      end
    end
    report_test("back_pressure");

    $display("summary: %0d tests run, %0d failed, %0d checks failed",
             tests_run, tests_failed, errors);
    if (errors == 0 && tests_failed == 0)
    begin
      $display("TESTS PASSED");
    end
    else
    begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule : tb_lcd_shield

`default_nettype wire

/* verilog.f */
verilog/lcd_cmd_pkg.sv
verilog/spi_link_pkg.sv
verilog/lcd_spi_serializer.sv
verilog/lcd_cmd_sequencer.sv
verilog/lcd_shield_top.sv
tests/spi_frame_monitor.sv
tests/tb_lcd_shield.sv

/* verilog/lcd_cmd_pkg.sv */
`default_nettype none

// command side of the tft shield controller
package lcd_cmd_pkg;

  // one command byte on the spi command port
  typedef logic [7:0] cmd_byte_t;

  // delay counter, wide enough for the default power-on wait
  typedef logic [20:0] delay_t;

  // st7735-style command codes
  localparam cmd_byte_t CMD_SLPOUT = 8'h11;
  localparam cmd_byte_t CMD_DISPON = 8'h29;
  localparam cmd_byte_t CMD_INVON  = 8'h21;
  localparam cmd_byte_t CMD_INVOFF = 8'h20;

  // gap between commands in clk cycles
  localparam delay_t DEFAULT_DELAY_CYCLES = 21'd625000;

  // sequencer fsm
  typedef enum logic [1:0] {
    SEQ_WAIT,
    SEQ_SEND,
    SEQ_RUN
  } seq_state_t;

endpackage : lcd_cmd_pkg

`default_nettype wire

/* verilog/lcd_cmd_sequencer.sv */
`timescale 1ns/1ps
`default_nettype none

// power-on wait, slpout and dispon, then invon/invoff forever
module lcd_cmd_sequencer
  import lcd_cmd_pkg::*;
#(
  parameter delay_t DELAY_CYCLES = DEFAULT_DELAY_CYCLES
)
(
  input  wire       clk,
  input  wire       rst,
  input  wire       cmd_ready,
  output logic      cmd_valid,
  output cmd_byte_t cmd_data,
  output logic      cmd_is_data,
  output logic      inv
);

  seq_state_t state;
  delay_t     delay_cnt;
  logic [1:0] cmd_idx;
  logic       accept;

  // offer held for the whole send state
  assign cmd_valid = (state == SEQ_SEND);
  assign accept = cmd_valid && cmd_ready;

  // only command bytes in this design
  assign cmd_is_data = 1'b0;

  // command list, index 0 is sent once after reset
  always_comb
  begin
    case (cmd_idx)
      2'd0:    cmd_data = CMD_SLPOUT;
      2'd1:    cmd_data = CMD_DISPON;
      2'd2:    cmd_data = CMD_INVON;
      default: cmd_data = CMD_INVOFF;
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state     <= SEQ_WAIT;
      // power-on delay before the first command
      delay_cnt <= DELAY_CYCLES;
      cmd_idx   <= 2'd0;
      inv       <= 1'b0;
    end
    else
    begin
      case (state)
        // count the delay down to zero
        SEQ_WAIT:
        begin
          if (delay_cnt == '0)
          begin
            state <= SEQ_SEND;
          end
          else
          begin
            delay_cnt <= delay_cnt - 1'b1;
          end
        end

        // hold until the serializer takes the byte
        SEQ_SEND:
        begin
          if (accept)
          begin
            state     <= SEQ_RUN;
            // next delay starts at the handshake
            delay_cnt <= DELAY_CYCLES;
            if (cmd_data == CMD_INVON)
            begin
              inv <= 1'b1;
            end
            else if (cmd_data == CMD_INVOFF)
            begin
              inv <= 1'b0;
            end
          end
        end

        // step the list, keep the delay running
        SEQ_RUN:
        begin
          state <= SEQ_WAIT;
          // after invoff go back to invon, never to slpout
          if (cmd_idx == 2'd3)
          begin
            cmd_idx <= 2'd2;
          end
          else
          begin
            cmd_idx <= cmd_idx + 1'b1;
          end
          if (delay_cnt != '0)
          begin
            delay_cnt <= delay_cnt - 1'b1;
          end
        end

        default:
        begin
          state <= SEQ_WAIT;
        end
      endcase
    end
  end

endmodule : lcd_cmd_sequencer

`default_nettype wire

/* verilog/lcd_shield_top.sv */
`timescale 1ns/1ps
`default_nettype none

// tft shield command controller, sequencer feeding the spi serializer
module lcd_shield_top
  import lcd_cmd_pkg::*;
#(
  parameter delay_t DELAY_CYCLES = DEFAULT_DELAY_CYCLES
)
(
  input  wire  clk,
  input  wire  rst,
  output logic inv,
  output logic sck,
  output logic rs_dc,
  output logic data,
  output logic cs
);

  // byte handshake between the two blocks
  logic      cmd_valid;
  logic      cmd_ready;
  logic      cmd_is_data;
  cmd_byte_t cmd_data;

  lcd_cmd_sequencer #(
    .DELAY_CYCLES (DELAY_CYCLES)
  ) seq_i (
    .clk         (clk),
    .rst         (rst),
    .cmd_ready   (cmd_ready),
    .cmd_valid   (cmd_valid),
    .cmd_data    (cmd_data),
    .cmd_is_data (cmd_is_data),
    .inv         (inv)
  );

  // display pins come straight from here
  lcd_spi_serializer ser_i (
    .clk         (clk),
    .rst         (rst),
    .cmd_valid   (cmd_valid),
    .cmd_data    (cmd_data),
    .cmd_is_data (cmd_is_data),
    .cmd_ready   (cmd_ready),
    .sck         (sck),
    .data        (data),
    .rs_dc       (rs_dc),
    .cs          (cs)
  );

endmodule : lcd_shield_top

`default_nettype wire

/* verilog/lcd_spi_serializer.sv */
`timescale 1ns/1ps
`default_nettype none

// sends one accepted byte as a write-only spi mode-0 frame, msb first
module lcd_spi_serializer
  import lcd_cmd_pkg::*, spi_link_pkg::*;
(
  input  wire            clk,
  input  wire            rst,
  input  wire            cmd_valid,
  input  wire cmd_byte_t cmd_data,
  input  wire            cmd_is_data,
  output logic           cmd_ready,
  output logic           sck,
  output logic           data,
  output logic           rs_dc,
  output logic           cs
);

  ser_state_t state;
  div_cnt_t   div_cnt;
  bit_cnt_t   bit_cnt;
  cmd_byte_t  shift_q;
  logic       accept;
  logic       bit_end;
  logic       last_bit;

  // only idle takes a new byte
  assign cmd_ready = (state == SER_IDLE);
  assign accept = cmd_valid && cmd_ready;

  // last clk cycle of the current bit period
  assign bit_end = (div_cnt == div_cnt_t'(SPI_CLK_DIV - 1));
  assign last_bit = (bit_cnt == bit_cnt_t'(7));

  // chip select low for the whole shift phase
  assign cs = (state != SER_SHIFT);

  // sck from upper half of the divider
  // low in the first half, rising edge mid-bit
  // so it stays locked to data
  assign sck = (state == SER_SHIFT) && (div_cnt >= div_cnt_t'(SPI_HALF_DIV));

  // fsm, counters and pin registers
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state   <= SER_IDLE;
      div_cnt <= '0;
      bit_cnt <= '0;
      data    <= 1'b0;
      rs_dc   <= 1'b0;
    end
    else
    begin
      case (state)
        SER_IDLE:
        begin
          if (accept)
          begin
            state   <= SER_SHIFT;
            div_cnt <= '0;
            bit_cnt <= '0;
            // bit 7 on the line from the first frame cycle
            data    <= cmd_data[7];
            // d/c low marks a command byte
            rs_dc   <= cmd_is_data;
          end
        end

        SER_SHIFT:
        begin
          if (bit_end)
          begin
            div_cnt <= '0;
            if (last_bit)
            begin
              // frame done, park the line low
              state <= SER_GAP;
              data  <= 1'b0;
            end
            else
            begin
              bit_cnt <= bit_cnt + 1'b1;
              // next bit lands with sck low
              data    <= shift_q[6];
            end
          end
          else
          begin
            div_cnt <= div_cnt + 1'b1;
          end
        end

        // one cycle with cs high between frames
        SER_GAP:
        begin
          state <= SER_IDLE;
        end

        default:
        begin
          state <= SER_IDLE;
        end
      endcase
    end
  end

  // byte being shifted, msb is always the bit on the line
  always_ff @(posedge clk)
  begin
    if (accept)
    begin
      shift_q <= cmd_data;
    end
    else if ((state == SER_SHIFT) && bit_end)
    begin
      shift_q <= {shift_q[6:0], 1'b0};
    end
  end

endmodule : lcd_spi_serializer

`default_nettype wire

/* verilog/spi_link_pkg.sv */
`default_nettype none

// serial link side, spi mode 0, write only
package spi_link_pkg;

  // clk cycles per sck bit period
  localparam int SPI_CLK_DIV = 16;

  // sck goes high for the second half of a bit
  localparam int SPI_HALF_DIV = SPI_CLK_DIV / 2;

  // position inside one bit period
  typedef logic [$clog2(SPI_CLK_DIV)-1:0] div_cnt_t;

  // bit position inside a byte
  typedef logic [2:0] bit_cnt_t;

  // serializer fsm
  typedef enum logic [1:0] {
    SER_IDLE,
    SER_SHIFT,
    SER_GAP
  } ser_state_t;

endpackage : spi_link_pkg

`default_nettype wire
